//--- Makefile
# board control fpga, verilator flow
TOP = board_ctrl_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- hw/board_ctrl_top.sv
/*
  source-measure board control fpga top
  host spi receiver, control registers and peripheral spi steering
*/
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_top
  import spi_frame_pkg::*, board_map_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        sclk,
  input  logic        cs_n,
  input  logic        mosi,
  input  logic        cs2_n,
  input  logic [3:0]  periph_miso,
  output logic        miso,
  output logic [3:0]  periph_cs_n,
  output board_ctrl_t ctrl
);

  // adc, dac, flash and spare
  localparam int n_periph = 4;

  frame_t     frame;
  logic       frame_valid;
  logic [7:0] rd_addr;
  nibble_t    rd_data;
  logic       dout;

  //////////////////////////////////////////////////
  // host frame path
  //////////////////////////////////////////////////

  spi_frame_rx rx_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .frame       (frame),
    .frame_valid (frame_valid),
    .dout        (dout)
  );

  ctrl_reg_bank regs_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .ctrl        (ctrl)
  );

  //////////////////////////////////////////////////
  // peripheral steering
  //////////////////////////////////////////////////

  periph_spi_mux #(
    .n_periph (n_periph)
  ) mux_i (
    .periph_sel  (ctrl.periph_sel[n_periph-1:0]),
    .cs2_n       (cs2_n),
    .dout        (dout),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

`default_nettype wire

//--- hw/board_map_pkg.sv
/*
  source-measure board register map
  addresses, the register struct and the board-safe values
*/
`default_nettype none

package board_map_pkg;

  //////////////////////////////////////////////////
  // register addresses
  //////////////////////////////////////////////////

  localparam logic [7:0] addr_led        = 8'd7;
  localparam logic [7:0] addr_periph_sel = 8'd8;
  localparam logic [7:0] addr_dac        = 8'd9;
  localparam logic [7:0] addr_rails      = 8'd10;
  // not a register, writing here restores safe values
  localparam logic [7:0] addr_soft_reset = 8'd11;
  localparam logic [7:0] addr_adc        = 8'd14;
  localparam logic [7:0] addr_clamp1     = 8'd15;
  localparam logic [7:0] addr_clamp2     = 8'd16;
  localparam logic [7:0] addr_rails_oe   = 8'd24;

  //////////////////////////////////////////////////
  // control word, eight nibbles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0] led;
    logic [3:0] periph_sel;
    logic [3:0] dac;
    logic [3:0] rails;
    logic [3:0] rails_oe;
    logic [3:0] adc;
    logic [3:0] clamp1;
    logic [3:0] clamp2;
  } board_ctrl_t;

  // board-safe state
  // clamps are active low, all off
  // rails output enable active low, keep rails off until host is ready
  localparam board_ctrl_t ctrl_reset_value = '{
    led:        4'b0000,
    periph_sel: 4'b0000,
    dac:        4'b0000,
    rails:      4'b0000,
    rails_oe:   4'b0001,
    adc:        4'b0000,
    clamp1:     4'b1111,
    clamp2:     4'b1111
  };

endpackage

`default_nettype wire

//--- hw/ctrl_reg_bank.sv
/*
  board control register bank
  applies set/clear/toggle frames, soft reset and readback decode
*/
`timescale 1ns/1ns
`default_nettype none

module ctrl_reg_bank
  import spi_frame_pkg::*, board_map_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  frame_t      frame,
  input  logic        frame_valid,
  input  logic [7:0]  rd_addr,
  output nibble_t     rd_data,
  output board_ctrl_t ctrl
);

  //////////////////////////////////////////////////
  // update rule
  //////////////////////////////////////////////////

  // any overlap between set and clear toggles just those bits
  // otherwise or in the set bits, then force the clear bits low
  function automatic nibble_t apply_frame(input nibble_t old_val, input frame_t f);
    nibble_t tgl;
    tgl = f.set & f.clr;
    if (|tgl)
    begin
      apply_frame = old_val ^ tgl;
    end
    else
    begin
      apply_frame = (old_val | f.set) & ~f.clr;
    end
  endfunction

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl <= ctrl_reset_value;
    end
    else if (frame_valid)
    begin
      case (frame.addr)
        addr_led:        ctrl.led        <= apply_frame(ctrl.led, frame);
        addr_periph_sel: ctrl.periph_sel <= apply_frame(ctrl.periph_sel, frame);
        addr_dac:        ctrl.dac        <= apply_frame(ctrl.dac, frame);
        addr_rails:      ctrl.rails      <= apply_frame(ctrl.rails, frame);
        addr_rails_oe:   ctrl.rails_oe   <= apply_frame(ctrl.rails_oe, frame);
        addr_adc:        ctrl.adc        <= apply_frame(ctrl.adc, frame);
        addr_clamp1:     ctrl.clamp1     <= apply_frame(ctrl.clamp1, frame);
        addr_clamp2:     ctrl.clamp2     <= apply_frame(ctrl.clamp2, frame);
        // value byte is don't care for soft reset
        addr_soft_reset: ctrl            <= ctrl_reset_value;
        default:
        begin
          // unmapped address, frame dropped
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback decode
  //////////////////////////////////////////////////

  // current value, before this frame's update
  always_comb
  begin
    case (rd_addr)
      addr_led:        rd_data = ctrl.led;
      addr_periph_sel: rd_data = ctrl.periph_sel;
      addr_dac:        rd_data = ctrl.dac;
      addr_rails:      rd_data = ctrl.rails;
      addr_rails_oe:   rd_data = ctrl.rails_oe;
      addr_adc:        rd_data = ctrl.adc;
      addr_clamp1:     rd_data = ctrl.clamp1;
      addr_clamp2:     rd_data = ctrl.clamp2;
      // soft reset and unmapped read as zero
      default:         rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/periph_spi_mux.sv
/*
  peripheral spi steering
  cs2_n fans out to the selected chip-selects, miso picks the source
*/
`timescale 1ns/1ns
`default_nettype none

module periph_spi_mux #(
  parameter int n_periph = 4
) (
  input  logic [n_periph-1:0] periph_sel,
  input  logic                cs2_n,
  input  logic                dout,
  input  logic [n_periph-1:0] periph_miso,
  output logic [n_periph-1:0] periph_cs_n,
  output logic                miso
);

  // cs2_n high means host talks to us, peripherals all deselected
  // cs2_n low passes the frame through to every selected peripheral
  always_comb
  begin
    if (cs2_n)
    begin
      periph_cs_n = '1;
      miso        = dout;
    end
    else
    begin
      periph_cs_n = ~periph_sel;
      // more than one select is allowed, their miso lines are ored
      miso        = |(periph_sel & periph_miso);
    end
  end

endmodule

`default_nettype wire

//--- hw/spi_frame_pkg.sv
/*
  host spi link frame layout
  one 16 bit word per frame, address byte first, then clear and set nibbles
*/
`default_nettype none

package spi_frame_pkg;

  // bits per host frame, msb first on the wire
  localparam int frame_bits = 16;

  // one control register value
  typedef logic [3:0] nibble_t;

  //////////////////////////////////////////////////
  // frame word
  //////////////////////////////////////////////////

  // first byte shifted in is the address
  // low nibble of the value byte sets, high nibble clears
  // overlapping set and clear bits mean toggle
  typedef struct packed {
    logic [7:0] addr;
    nibble_t    clr;
    nibble_t    set;
  } frame_t;

endpackage

`default_nettype wire

//--- hw/spi_frame_rx.sv
/*
  host spi frame receiver
  samples sclk, cs_n and mosi into clk, collects 16 bit frames
  and shifts the addressed register nibble back out
*/
`timescale 1ns/1ns
`default_nettype none

module spi_frame_rx
  import spi_frame_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  input  nibble_t    rd_data,
  output logic [7:0] rd_addr,
  output frame_t     frame,
  output logic       frame_valid,
  output logic       dout
);

  localparam int cnt_w     = $clog2(frame_bits) + 1;
  localparam int addr_bits = $bits(rd_addr);
  localparam int nib_bits  = $bits(nibble_t);

  // [0] and [1] sync stages, [2] previous value for edges
  logic [2:0] sclk_q;
  logic [2:0] cs_q;
  logic [1:0] mosi_q;

  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_rise;
  logic                  cs_fall;
  logic                  addr_done;
  logic                  rd_load;
  logic [cnt_w-1:0]      bit_cnt;
  logic [frame_bits-1:0] shift_q;
  logic [2*nib_bits-1:0] out_q;

  //////////////////////////////////////////////////
  // synchronizers and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_q <= '0;
      // cs idles high, no false frame start out of reset
      cs_q   <= '1;
      mosi_q <= '0;
    end
    else
    begin
      sclk_q <= {sclk_q[1:0], sclk};
      cs_q   <= {cs_q[1:0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  // sclk edges only count inside our own frame
  // peripherals see the same sclk while cs2_n is low
  assign sclk_rise = sclk_q[1] & ~sclk_q[2] & ~cs_q[1];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2] & ~cs_q[1];
  assign cs_fall   = ~cs_q[1] & cs_q[2];
  assign cs_rise   = cs_q[1] & ~cs_q[2];
  assign addr_done = sclk_rise && (bit_cnt == cnt_w'(addr_bits - 1));

  //////////////////////////////////////////////////
  // mosi shift and bit count
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      shift_q     <= '0;
      bit_cnt     <= '0;
      rd_addr     <= '0;
      rd_load     <= 1'b0;
      frame_valid <= 1'b0;
    end
    else
    begin
      // short and long frames are dropped here
      frame_valid <= cs_rise && (bit_cnt == cnt_w'(frame_bits));
      rd_load     <= addr_done;
      if (cs_fall)
      begin
        bit_cnt <= '0;
      end
      else if (sclk_rise)
      begin
        shift_q <= {shift_q[frame_bits-2:0], mosi_q[1]};
        // saturate so very long frames never wrap back to 16
        if (bit_cnt != '1)
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      // eighth bit completes the address byte
      if (addr_done)
      begin
        rd_addr <= {shift_q[addr_bits-2:0], mosi_q[1]};
      end
    end
  end

  assign frame = frame_t'(shift_q);

  //////////////////////////////////////////////////
  // readback on miso
  //////////////////////////////////////////////////

  // four zero bits, then the nibble msb first
  // nibble lands one clk after the address, well before the next sclk fall
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_q <= '0;
      dout  <= 1'b0;
    end
    else if (cs_fall)
    begin
      out_q <= '0;
      dout  <= 1'b0;
    end
    else if (rd_load)
    begin
      out_q <= {{nib_bits{1'b0}}, rd_data};
    end
    else if (sclk_fall)
    begin
      dout  <= out_q[2*nib_bits-1];
      out_q <= {out_q[2*nib_bits-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

//--- list.f
hw/spi_frame_pkg.sv
hw/board_map_pkg.sv
hw/spi_frame_rx.sv
hw/ctrl_reg_bank.sv
hw/periph_spi_mux.sv
hw/board_ctrl_top.sv
testbench/board_ctrl_checker.sv
testbench/board_ctrl_tb.sv

//--- testbench/board_ctrl_checker.sv
/*
  bound checks on the board control top
  chip-select steering, miso source and state after reset
*/
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_checker
  import board_map_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input logic        cs2_n,
  input logic        miso,
  input logic        dout,
  input logic [3:0]  periph_cs_n,
  input board_ctrl_t ctrl
);

  //////////////////////////////////////////////////
  // peripheral steering
  //////////////////////////////////////////////////

  // host owns the link, peripherals idle, readback on miso
  a_host_owns: assert property (@(posedge clk) disable iff (!arst_n)
    cs2_n |-> (periph_cs_n == 4'b1111) && (miso == dout))
    else $error("peripheral chip-select low or miso not from readback while cs2_n high");

  // each chip-select follows its select bit
  a_cs_follow: assert property (@(posedge clk) disable iff (!arst_n)
    !cs2_n |-> (periph_cs_n == ~ctrl.periph_sel))
    else $error("peripheral chip-selects do not follow periph_sel while cs2_n low");

  //////////////////////////////////////////////////
  // reset state
  //////////////////////////////////////////////////

  // safe values hold right after release
  a_reset_value: assert property (@(posedge clk)
    $rose(arst_n) |=> (ctrl == ctrl_reset_value))
    else $error("control registers not at board-safe values after reset");

endmodule

bind board_ctrl_top board_ctrl_checker chk_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .cs2_n       (cs2_n),
  .miso        (miso),
  .dout        (dout),
  .periph_cs_n (periph_cs_n),
  .ctrl        (ctrl)
);

`default_nettype wire

//--- testbench/board_ctrl_tb.sv
/*
  testbench for the board control fpga
  drives host spi frames, keeps a shadow register model, checks ctrl,
  readback on miso and peripheral chip-select steering
*/
`timescale 1ns/1ns
`default_nettype none

module board_ctrl_tb
  import spi_frame_pkg::*, board_map_pkg::*;
();

  // about 65 frames of roughly 145 clk each, then doubled
  localparam int timeout_cycles = 20000;

  logic        clk;
  logic        arst_n;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        cs2_n;
  logic [3:0]  periph_miso;
  logic        miso;
  logic [3:0]  periph_cs_n;
  board_ctrl_t ctrl;

  board_ctrl_t model;
  logic [31:0] rng_state;
  int          cycles;
  int          tests;
  int          checks;
  int          errors;
  int          test_start;

  board_ctrl_top dut_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .ctrl        (ctrl)
  );

  always #10 clk = ~clk;

  // run limit
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles)
    begin
      $display("timeout: tests still running after %0d clock cycles", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers and reference model
  //////////////////////////////////////////////////

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // one of the eight kept registers
  function automatic logic [7:0] pick_addr(input logic [2:0] idx);
    case (idx)
      3'd0: return addr_led;
      3'd1: return addr_periph_sel;
      3'd2: return addr_dac;
      3'd3: return addr_rails;
      3'd4: return addr_rails_oe;
      3'd5: return addr_adc;
      3'd6: return addr_clamp1;
      default: return addr_clamp2;
    endcase
  endfunction

  // unmapped and soft reset read as zero
  function automatic nibble_t field_of(input board_ctrl_t c, input logic [7:0] a);
    case (a)
      addr_led:        return c.led;
      addr_periph_sel: return c.periph_sel;
      addr_dac:        return c.dac;
      addr_rails:      return c.rails;
      addr_rails_oe:   return c.rails_oe;
      addr_adc:        return c.adc;
      addr_clamp1:     return c.clamp1;
      addr_clamp2:     return c.clamp2;
      default:         return 4'b0000;
    endcase
  endfunction

  function automatic board_ctrl_t with_field(input board_ctrl_t c, input logic [7:0] a,
                                             input nibble_t v);
    board_ctrl_t r;
    r = c;
    case (a)
      addr_led:        r.led        = v;
      addr_periph_sel: r.periph_sel = v;
      addr_dac:        r.dac        = v;
      addr_rails:      r.rails      = v;
      addr_rails_oe:   r.rails_oe   = v;
      addr_adc:        r.adc        = v;
      addr_clamp1:     r.clamp1     = v;
      addr_clamp2:     r.clamp2     = v;
      default:         r            = c;
    endcase
    return r;
  endfunction

  // bitwise view of the rule, clear wins over set when no overlap
  function automatic nibble_t apply_rule(input nibble_t old, input nibble_t clr,
                                         input nibble_t set);
    nibble_t both;
    nibble_t res;
    both = set & clr;
    res  = old;
    if (both != 4'b0000)
    begin
      res = old ^ both;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (clr[i])
          res[i] = 1'b0;
        else if (set[i])
          res[i] = 1'b1;
      end
    end
    return res;
  endfunction

  // high if any selected peripheral drives its miso high
  function automatic logic peripheral_miso(input nibble_t sel, input logic [3:0] pm);
    logic any;
    any = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      if (sel[i] && pm[i])
        any = 1'b1;
    end
    return any;
  endfunction

  // n clk edges, then the 2 ns drive offset
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // mode 0, sclk at clk/8, miso sampled just before each sclk rise
  task automatic send_frame(input logic [16:0] data, input int nbits,
                            output logic [16:0] rx);
    rx   = '0;
    cs_n = 1'b0;
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi = data[i];
      step(4);
      rx   = {rx[15:0], miso};
      sclk = 1'b1;
      step(4);
      sclk = 1'b0;
    end
    step(4);
    cs_n = 1'b1;
    mosi = 1'b0;
  endtask

  task automatic check_ctrl(input string what);
    checks++;
    assert (ctrl === model)
    else
    begin
      $display("Fail at %0t ns: %s, ctrl %h expected %h", $time, what, ctrl, model);
      errors++;
    end
  endtask

  // full frame, model update, then ctrl and readback checks
  task automatic write_reg(input logic [7:0] addr, input nibble_t clr, input nibble_t set);
    nibble_t     old;
    logic [16:0] rx;
    old = field_of(model, addr);
    send_frame({1'b0, addr, clr, set}, frame_bits, rx);
    if (addr == addr_soft_reset)
      model = ctrl_reset_value;
    else
      model = with_field(model, addr, apply_rule(old, clr, set));
    step(6);
    check_ctrl($sformatf("write to addr %0d", addr));
    if (cs2_n)
    begin
      checks++;
      // last four miso bits carry the value before this frame
      assert (rx[3:0] === old)
      else
      begin
        $display("Fail at %0t ns: readback of addr %0d gave %h, expected %h",
                 $time, addr, rx[3:0], old);
        errors++;
      end
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - test_start);
    test_start = errors;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    logic [16:0] rx;
    nibble_t     ov;
    clk         = 1'b0;
    arst_n      = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    cs2_n       = 1'b1;
    periph_miso = 4'b0000;
    model       = ctrl_reset_value;
    rng_state   = 32'd13;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    test_start  = 0;
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    step(2);

    // clamps high, rails_oe 0001, rest zero
    check_ctrl("reset value");
    end_test("reset values");

    for (int i = 0; i < 8; i++)
    begin
      r = next_rand();
      write_reg(pick_addr(i[2:0]), 4'b0000, r[3:0]);
      write_reg(pick_addr(i[2:0]), r[7:4], 4'b0000);
    end
    repeat (12)
    begin
      r = next_rand();
      write_reg(pick_addr(r[2:0]), r[15:12] & ~r[11:8], r[11:8]);
    end
    end_test("set, clear and or-then-clear");

    // overlap is exactly ov
    repeat (10)
    begin
      r  = next_rand();
      ov = (r[7:4] == 4'b0000) ? 4'b0100 : r[7:4];
      write_reg(pick_addr(r[2:0]), ov | (r[15:12] & ~r[11:8]), ov | r[11:8]);
    end
    end_test("overlap toggles");

    repeat (6)
    begin
      r = next_rand();
      write_reg(pick_addr(r[2:0]), r[15:12], r[11:8]);
    end
    r = next_rand();
    // value byte is ignored, a zero last bit lines a short frame up on addr_led
    write_reg(addr_soft_reset, r[7:4], {r[3:1], 1'b0});
    checks++;
    assert (ctrl === ctrl_reset_value)
    else
    begin
      $display("Fail at %0t ns: soft reset left ctrl at %h", $time, ctrl);
      errors++;
    end
    // toggle-all frames that would change led if accepted
    send_frame({1'b0, addr_led, 4'hf, 4'hf}, 15, rx);
    step(6);
    check_ctrl("15 bit frame");
    send_frame({1'b1, addr_led, 4'hf, 4'hf}, 17, rx);
    step(6);
    check_ctrl("17 bit frame");
    end_test("soft reset and bad length");

    // readback is checked inside write_reg while cs2_n is high
    repeat (10)
    begin
      r = next_rand();
      write_reg(pick_addr(r[2:0]), r[15:12] & ~r[11:8], r[11:8]);
    end
    end_test("miso readback");

    repeat (8)
    begin
      r = next_rand();
      // no overlap, so the register takes r[3:0] exactly
      write_reg(addr_periph_sel, ~r[3:0], r[3:0]);
      cs2_n = 1'b0;
      repeat (3)
      begin
        r           = next_rand();
        periph_miso = r[3:0];
        step(1);
        checks += 2;
        assert (periph_cs_n === ~model.periph_sel)
        else
        begin
          $display("Fail at %0t ns: periph_cs_n %b for select %b",
                   $time, periph_cs_n, model.periph_sel);
          errors++;
        end
        assert (miso === peripheral_miso(model.periph_sel, periph_miso))
        else
        begin
          $display("Fail at %0t ns: miso %b, select %b, periph_miso %b",
                   $time, miso, model.periph_sel, periph_miso);
          errors++;
        end
      end
      cs2_n       = 1'b1;
      periph_miso = 4'b0000;
      step(1);
    end
    end_test("peripheral steering");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
